/* hdl/frame_pkg.sv */
package frame_pkg;

    localparam int NUM_DEV  = 8;
    localparam int NUM_SLOT = 6;
    localparam int DEV_W    = 10;             // 2-bit code + 8-bit temperature
    localparam int STAT_W   = NUM_DEV * DEV_W;
    localparam int SLOT_W   = 3;
    localparam int LEN_W    = 10;

    localparam int PADDR_W = 17;
    localparam int WIN_BIT = 16;
    localparam int SMP_AW  = 12;
    localparam int SMP_DW  = 64;
    localparam int TX_AW   = 15;

    localparam logic [3:0] BTYPE_INFO = 4'h1;
    localparam logic [3:0] BTYPE_DATA = 4'hE;

    localparam logic [TX_AW-1:0] TXA_INFO = 15'h0100;
    localparam logic [TX_AW-1:0] TXA_SLOT [NUM_SLOT] =
        '{15'h1000, 15'h2200, 15'h3400, 15'h4600, 15'h5800, 15'h6A00};
    localparam logic [SMP_AW-1:0] RXA_SLOT [NUM_SLOT] =
        '{12'h000, 12'h240, 12'h480, 12'h6C0, 12'h900, 12'hB40};

    // Payload bytes per device status code
    localparam logic [LEN_W-1:0] DLEN [4] = '{10'd0, 10'd128, 10'd256, 10'd512};

    localparam int INFO_LEN       = 14;
    localparam int HEAD_LEN       = 4;
    localparam int TRIG_LEN       = 4;
    localparam int SAMPLE_LATENCY = 2;

    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_STATUS = 8'h04;
    localparam logic [7:0] REG_TRIG   = 8'h08;
    localparam logic [7:0] REG_STAT0  = 8'h0C;
    localparam logic [7:0] REG_STAT1  = 8'h10;
    localparam logic [7:0] REG_STAT2  = 8'h14;

    // Builder states
    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_INFO  = 3'd1;
    localparam logic [2:0] ST_HEAD  = 3'd2;
    localparam logic [2:0] ST_NEXT  = 3'd3;
    localparam logic [2:0] ST_PRIME = 3'd4;
    localparam logic [2:0] ST_LOAD  = 3'd5;
    localparam logic [2:0] ST_TRIG  = 3'd6;
    localparam logic [2:0] ST_DONE  = 3'd7;

    typedef union packed {
        logic [STAT_W-1:0]             raw;
        logic [0:NUM_DEV-1][DEV_W-1:0] dev;   // Entry 0 in the top bits
    } dev_status_u;

endpackage

/* hdl/sample_ram.sv */
module sample_ram (
    input  logic                         clk,
    input  logic                         we,
    input  logic [frame_pkg::SMP_AW-1:0] waddr,
    input  logic [frame_pkg::SMP_DW-1:0] wdata,
    input  logic [frame_pkg::SMP_AW-1:0] raddr,
    output logic [frame_pkg::SMP_DW-1:0] rdata
);
    import frame_pkg::*;

    logic [SMP_DW-1:0] mem [2**SMP_AW];
    logic [SMP_AW-1:0] raddr_q;

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // Address register then output register
    always_ff @(posedge clk) begin
        raddr_q <= raddr;
        rdata   <= mem[raddr_q];
    end

endmodule

/* hdl/frame_ram.sv */
module frame_ram (
    input  logic                        clk,
    input  logic                        we,
    input  logic [frame_pkg::TX_AW-1:0] waddr,
    input  logic [7:0]                  wdata,
    input  logic [frame_pkg::TX_AW-1:0] raddr,
    output logic [7:0]                  rdata
);
    import frame_pkg::*;

    logic [7:0] mem [2**TX_AW];

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    always_ff @(posedge clk) begin
        rdata <= mem[raddr];    // APB window side
    end

endmodule

/* hdl/frame_regs.sv */
module frame_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [frame_pkg::PADDR_W-1:0] paddr,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  logic                          fd,
    output logic                          fs,
    output logic [3:0]                    btype,
    output logic [31:0]                   trig_word,
    output frame_pkg::dev_status_u        dev_status,
    input  logic [frame_pkg::SLOT_W-1:0]  slot,
    output logic [frame_pkg::TX_AW-1:0]   win_addr,
    input  logic [7:0]                    win_data
);
    import frame_pkg::*;

    logic        win_sel;
    logic        setup;
    logic        win_wait;
    logic        wr_en;
    logic        start_req;
    logic        start_bad;
    logic        done;
    logic [31:0] rd_mux;

    assign win_sel   = paddr[WIN_BIT];
    assign setup     = psel & ~penable;
    assign win_wait  = psel & penable & ~pready & win_sel;   // RAM data valid here
    assign wr_en     = psel & penable & pready & pwrite & ~win_sel;
    assign win_addr  = paddr[TX_AW-1:0];

    assign start_req = pwrite && (paddr[7:0] == REG_CTRL) && pwdata[0];
    assign start_bad = fs || ((pwdata[7:4] != BTYPE_INFO) && (pwdata[7:4] != BTYPE_DATA));

    always_comb begin
        case (paddr[7:0])
            REG_CTRL:   rd_mux = {24'd0, btype, 3'd0, fs};
            REG_STATUS: rd_mux = {24'd0, 1'b0, slot, 2'b00, done, fs};
            REG_TRIG:   rd_mux = trig_word;
            REG_STAT0:  rd_mux = dev_status.raw[STAT_W-1 -: 32];
            REG_STAT1:  rd_mux = dev_status.raw[STAT_W-33 -: 32];
            REG_STAT2:  rd_mux = {16'd0, dev_status.raw[15:0]};
            default:    rd_mux = 32'd0;
        endcase
    end

    // Register replies are decided in the setup phase, window replies one cycle late
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            pready  <= (setup & ~win_sel) | win_wait;
            pslverr <= setup & ~win_sel & start_req & start_bad;
        end
    end

    always_ff @(posedge clk) begin
        if (setup && !win_sel)
            prdata <= rd_mux;
        else if (win_wait)
            prdata <= {24'd0, win_data};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fs         <= 1'b0;
            done       <= 1'b0;
            btype      <= 4'd0;
            trig_word  <= 32'd0;
            dev_status <= '0;
        end else begin
            if (fd) begin
                fs   <= 1'b0;
                done <= 1'b1;
            end
            if (wr_en) begin
                case (paddr[7:0])
                    REG_CTRL: begin
                        if (pwdata[0] && !pslverr) begin
                            fs    <= 1'b1;
                            done  <= 1'b0;
                            btype <= pwdata[7:4];
                        end
                    end
                    REG_TRIG:  trig_word <= pwdata;
                    REG_STAT0: dev_status.raw[STAT_W-1 -: 32] <= pwdata;
                    REG_STAT1: dev_status.raw[STAT_W-33 -: 32] <= pwdata;
                    REG_STAT2: dev_status.raw[15:0] <= pwdata[15:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

/* hdl/frame_builder.sv */
module frame_builder (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fs,
    input  logic [3:0]                   btype,
    input  frame_pkg::dev_status_u       dev_status,
    input  logic [31:0]                  trig_word,
    output logic                         fd,
    output logic [frame_pkg::SLOT_W-1:0] slot,
    output logic                         tx_we,
    output logic [frame_pkg::TX_AW-1:0]  tx_addr,
    output logic [7:0]                   tx_data,
    output logic [frame_pkg::SMP_AW-1:0] rx_addr,
    input  logic [frame_pkg::SMP_DW-1:0] rx_data
);
    import frame_pkg::*;

    logic [2:0]                   state;
    logic [LEN_W-1:0]             cnt;
    logic [LEN_W-1:0]             len;
    logic [$clog2(NUM_DEV)-1:0]   dev_idx;
    logic [$clog2(NUM_DEV)-1:0]   tidx;
    logic [SLOT_W-1:0]            slot_nx;
    logic [0:NUM_DEV-1][1:0]      codes;
    logic [0:NUM_DEV-1]           active;
    logic [0:NUM_DEV-1][7:0]      lanes;
    logic [0:TRIG_LEN-1][7:0]     trig_b;
    logic                         last_dev;
    logic                         wr;
    logic [7:0]                   byte_d;

    always_comb begin
        for (int i = 0; i < NUM_DEV; i++) begin
            codes[i]  = dev_status.dev[i][DEV_W-1 -: 2];
            active[i] = |dev_status.dev[i][DEV_W-1 -: 2];
        end
    end

    assign lanes    = rx_data;                  // Lane 0 is the top byte
    assign trig_b   = trig_word;
    assign tidx     = cnt[2:0] - 3'd6;          // Info bytes 6..13 carry temperatures
    assign slot_nx  = (slot == SLOT_W'(NUM_SLOT - 1)) ? '0 : slot + 1'b1;
    assign last_dev = (dev_idx == $clog2(NUM_DEV)'(NUM_DEV - 1));
    assign fd       = (state == ST_DONE);

    assign wr = (state == ST_INFO) || (state == ST_HEAD) ||
                (state == ST_LOAD) || (state == ST_TRIG);

    always_comb begin
        byte_d = lanes[dev_idx];
        case (state)
            ST_INFO: begin
                case (cnt[3:0])
                    4'd0:    byte_d = 8'h66;
                    4'd1:    byte_d = 8'hBB;
                    4'd2:    byte_d = 8'h00;
                    4'd3:    byte_d = 8'h1E;
                    4'd4:    byte_d = codes[0:3];
                    4'd5:    byte_d = codes[4:7];
                    default: byte_d = dev_status.dev[tidx][7:0];
                endcase
            end
            ST_HEAD: begin
                case (cnt[1:0])
                    2'd0:    byte_d = 8'h55;
                    2'd1:    byte_d = 8'hAA;
                    2'd2:    byte_d = active;
                    default: byte_d = 8'(slot);
                endcase
            end
            ST_TRIG: byte_d = trig_b[cnt[1:0]];
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            cnt     <= '0;
            dev_idx <= '0;
            slot    <= '0;
            tx_we   <= 1'b0;
        end else begin
            tx_we <= wr;
            cnt   <= cnt + 1'b1;
            case (state)
                ST_IDLE: begin
                    cnt <= '0;
                    if (fs) begin
                        if (btype == BTYPE_INFO) begin
                            state <= ST_INFO;
                        end else begin
                            state <= ST_HEAD;
                            slot  <= slot_nx;   // Slot moves before the header goes out
                        end
                    end
                end
                ST_INFO: begin
                    if (cnt == LEN_W'(INFO_LEN - 1))
                        state <= ST_DONE;
                end
                ST_HEAD: begin
                    if (cnt == LEN_W'(HEAD_LEN - 1)) begin
                        state   <= ST_NEXT;
                        dev_idx <= '0;
                    end
                end
                ST_NEXT: begin
                    cnt <= '0;
                    if (active[dev_idx])
                        state <= ST_PRIME;
                    else if (last_dev)
                        state <= ST_TRIG;
                    else
                        dev_idx <= dev_idx + 1'b1;
                end
                ST_PRIME: begin
                    // Fill the sample read pipeline
                    if (cnt == LEN_W'(SAMPLE_LATENCY - 1)) begin
                        cnt   <= '0;
                        state <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    if (cnt == len - 1'b1) begin
                        cnt <= '0;
                        if (last_dev) begin
                            state <= ST_TRIG;
                        end else begin
                            dev_idx <= dev_idx + 1'b1;
                            state   <= ST_NEXT;
                        end
                    end
                end
                ST_TRIG: begin
                    if (cnt == LEN_W'(TRIG_LEN - 1))
                        state <= ST_DONE;
                end
                default: begin
                    if (!fs)
                        state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        tx_data <= byte_d;
        if (wr)
            tx_addr <= tx_addr + 1'b1;
        case (state)
            ST_IDLE: tx_addr <= (btype == BTYPE_INFO) ? TXA_INFO - 1'b1
                                                      : TXA_SLOT[slot_nx] - 1'b1;
            ST_NEXT: begin
                rx_addr <= RXA_SLOT[slot];
                len     <= DLEN[codes[dev_idx]];
            end
            ST_PRIME, ST_LOAD: rx_addr <= rx_addr + 1'b1;   // Runs ahead by the read latency
            default: ;
        endcase
    end

endmodule

/* hdl/frame_top.sv */
module frame_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [frame_pkg::PADDR_W-1:0] paddr,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  logic                          smp_we,
    input  logic [frame_pkg::SMP_AW-1:0]  smp_addr,
    input  logic [frame_pkg::SMP_DW-1:0]  smp_data
);
    import frame_pkg::*;

    logic              fs;
    logic              fd;
    logic [3:0]        btype;
    logic [31:0]       trig_word;
    dev_status_u       dev_status;
    logic [SLOT_W-1:0] slot;
    logic [TX_AW-1:0]  win_addr;
    logic [7:0]        win_data;
    logic              tx_we;
    logic [TX_AW-1:0]  tx_addr;
    logic [7:0]        tx_data;
    logic [SMP_AW-1:0] rx_addr;
    logic [SMP_DW-1:0] rx_data;

    frame_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .fd         (fd),
        .fs         (fs),
        .btype      (btype),
        .trig_word  (trig_word),
        .dev_status (dev_status),
        .slot       (slot),
        .win_addr   (win_addr),
        .win_data   (win_data)
    );

    frame_builder u_builder (
        .clk        (clk),
        .rst        (rst),
        .fs         (fs),
        .btype      (btype),
        .dev_status (dev_status),
        .trig_word  (trig_word),
        .fd         (fd),
        .slot       (slot),
        .tx_we      (tx_we),
        .tx_addr    (tx_addr),
        .tx_data    (tx_data),
        .rx_addr    (rx_addr),
        .rx_data    (rx_data)
    );

    sample_ram u_sample_ram (
        .clk   (clk),
        .we    (smp_we),
        .waddr (smp_addr),
        .wdata (smp_data),
        .raddr (rx_addr),
        .rdata (rx_data)
    );

    frame_ram u_frame_ram (
        .clk   (clk),
        .we    (tx_we),
        .waddr (tx_addr),
        .wdata (tx_data),
        .raddr (win_addr),
        .rdata (win_data)
    );

endmodule

/* sim/tb_frame_top.sv */
module tb_frame_top;
    timeunit 1ns;
    timeprecision 100ps;
    import frame_pkg::*;

    // Longest data frame in builder cycles, all devices at code 3
    localparam int MAX_DATA_FRAME = HEAD_LEN + NUM_DEV * (512 + SAMPLE_LATENCY + 1) + TRIG_LEN + 2;
    localparam int NUM_FRAMES     = 9;
    localparam int POLL_GAP       = 20;
    localparam int MAX_POLLS      = MAX_DATA_FRAME / POLL_GAP + 4;
    localparam int APB_RD_CYCLES  = 4;
    localparam int WATCHDOG_CYCLES = 16 + NUM_FRAMES * (MAX_DATA_FRAME + 2 * POLL_GAP)
                                   + NUM_FRAMES * MAX_DATA_FRAME * APB_RD_CYCLES + 3 * 512 + 500;

    logic               clk = 1'b0;
    logic               rst;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [PADDR_W-1:0] paddr;
    logic [31:0]        pwdata;
    logic [31:0]        prdata;
    logic               pready;
    logic               pslverr;
    logic               smp_we;
    logic [SMP_AW-1:0]  smp_addr;
    logic [SMP_DW-1:0]  smp_data;

    logic [31:0]       lfsr_state = 32'hfe94_50d7;
    logic [SMP_DW-1:0] smp_model [2**SMP_AW];   // Mirror of the sample RAM
    logic [1:0]        codes [NUM_DEV];
    logic [7:0]        temps [NUM_DEV];
    logic [31:0]       trig;
    int                exp_slot;

    frame_top dut (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .smp_we   (smp_we),
        .smp_addr (smp_addr),
        .smp_data (smp_data)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int payload_len(input logic [1:0] code);
        return (code == 2'd0) ? 0 : (64 << code);   // 0, 128, 256, 512
    endfunction

    function automatic logic [31:0] status_word(input int slot, input logic done);
        return {24'd0, 1'b0, 3'(slot), 2'b00, done, 1'b0};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic apb_write(input logic [PADDR_W-1:0] addr, input logic [31:0] data,
                             output logic err);
        int waits;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        waits = -1;
        do begin
            @(posedge clk);
            waits++;
        end while (!pready);
        err = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
        if (waits != (addr[WIN_BIT] ? 1 : 0))
            abort_run("APB write took the wrong number of wait states");
    endtask

    task automatic apb_read(input logic [PADDR_W-1:0] addr, output logic [31:0] data);
        int waits;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        waits = -1;
        do begin
            @(posedge clk);
            waits++;
        end while (!pready);
        data = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
        if (waits != (addr[WIN_BIT] ? 1 : 0))
            abort_run("APB read took the wrong number of wait states");
    endtask

    task automatic start_frame(input logic [3:0] t, input logic expect_err);
        logic err;
        apb_write(PADDR_W'(REG_CTRL), {24'd0, t, 3'd0, 1'b1}, err);
        if (err !== expect_err)
            abort_run(expect_err ? "start was accepted but should have been rejected"
                                 : "valid start was rejected");
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int          polls;
        st = '0;
        polls = 0;
        while (st[1] !== 1'b1) begin
            if (polls == MAX_POLLS)
                abort_run("STATUS never reported done for the running frame");
            repeat (POLL_GAP) @(posedge clk);
            apb_read(PADDR_W'(REG_STATUS), st);
            polls++;
        end
    endtask

    task automatic check_status(input int slot);
        logic [31:0] st;
        apb_read(PADDR_W'(REG_STATUS), st);
        check_word("STATUS", st, status_word(slot, 1'b1));
    endtask

    // Entry 0 sits in the top bits of the 80-bit word
    task automatic set_status();
        logic [STAT_W-1:0] raw;
        logic              err;
        for (int i = 0; i < NUM_DEV; i++)
            raw[STAT_W-1-DEV_W*i -: DEV_W] = {codes[i], temps[i]};
        apb_write(PADDR_W'(REG_STAT0), raw[79:48], err);
        apb_write(PADDR_W'(REG_STAT1), raw[47:16], err);
        apb_write(PADDR_W'(REG_STAT2), {16'd0, raw[15:0]}, err);
    endtask

    task automatic set_trigger();
        logic err;
        trig = 32'(rand_bits(32));
        apb_write(PADDR_W'(REG_TRIG), trig, err);
    endtask

    task automatic load_rows(input logic [SMP_AW-1:0] base, input int n);
        logic [SMP_DW-1:0] w;
        for (int i = 0; i < n; i++) begin
            w = rand_bits(64);
            smp_model[base + SMP_AW'(i)] = w;
            @(posedge clk);
            smp_we   <= 1'b1;
            smp_addr <= base + SMP_AW'(i);
            smp_data <= w;
        end
        @(posedge clk);
        smp_we <= 1'b0;
    endtask

    task automatic expect_frame_byte(input logic [TX_AW-1:0] addr, input logic [7:0] exp);
        logic [31:0] data;
        apb_read({2'b10, addr}, data);
        check_byte($sformatf("frame byte 0x%h", addr), data[7:0], exp);
        if (data[31:8] !== 24'd0)
            abort_run("window read returned nonzero upper bits");
    endtask

    task automatic check_info_frame();
        logic [7:0] exp [INFO_LEN];
        exp[0] = 8'h66;
        exp[1] = 8'hBB;
        exp[2] = 8'h00;
        exp[3] = 8'h1E;
        exp[4] = {codes[0], codes[1], codes[2], codes[3]};
        exp[5] = {codes[4], codes[5], codes[6], codes[7]};
        for (int i = 0; i < NUM_DEV; i++)
            exp[6 + i] = temps[i];
        for (int i = 0; i < INFO_LEN; i++)
            expect_frame_byte(TXA_INFO + TX_AW'(i), exp[i]);
    endtask

    task automatic check_data_frame(input int slot, input logic full);
        logic [TX_AW-1:0]  a;
        logic [7:0]        mask;
        logic [SMP_AW-1:0] row;
        for (int d = 0; d < NUM_DEV; d++)
            mask[7 - d] = (codes[d] != 2'd0);
        a = TXA_SLOT[slot];
        expect_frame_byte(a, 8'h55);
        expect_frame_byte(a + 1'b1, 8'hAA);
        expect_frame_byte(a + 2'd2, mask);
        expect_frame_byte(a + 2'd3, 8'(slot));
        a = a + 3'd4;
        if (full) begin
            for (int d = 0; d < NUM_DEV; d++) begin
                for (int k = 0; k < payload_len(codes[d]); k++) begin
                    row = RXA_SLOT[slot] + SMP_AW'(k);
                    expect_frame_byte(a, smp_model[row][SMP_DW-1-8*d -: 8]);   // Lane d
                    a = a + 1'b1;
                end
            end
            for (int j = 0; j < TRIG_LEN; j++) begin
                expect_frame_byte(a, trig[31-8*j -: 8]);
                a = a + 1'b1;
            end
        end
    endtask

    task automatic write_read_back(input logic [7:0] offs, input string name,
                                   input logic [31:0] mask);
        logic [31:0] v;
        logic [31:0] r;
        logic        err;
        v = 32'(rand_bits(32));
        apb_write(PADDR_W'(offs), v, err);
        apb_read(PADDR_W'(offs), r);
        check_word(name, r, v & mask);
    endtask

    task automatic test_registers();
        logic [31:0] r;
        apb_read(PADDR_W'(REG_STATUS), r);
        check_word("STATUS", r, 32'd0);
        write_read_back(REG_TRIG, "TRIG", 32'hFFFF_FFFF);
        write_read_back(REG_STAT0, "STAT0", 32'hFFFF_FFFF);
        write_read_back(REG_STAT1, "STAT1", 32'hFFFF_FFFF);
        write_read_back(REG_STAT2, "STAT2", 32'h0000_FFFF);
    endtask

    task automatic test_info_frame();
        for (int i = 0; i < NUM_DEV; i++) begin
            codes[i] = 2'(rand_bits(2));
            temps[i] = 8'(rand_bits(8));
        end
        set_status();
        start_frame(BTYPE_INFO, 1'b0);
        wait_done();
        check_status(exp_slot);
        check_info_frame();
    endtask

    task automatic test_data_frame();
        codes = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd3, 2'd2, 2'd1, 2'd0};
        for (int i = 0; i < NUM_DEV; i++)
            temps[i] = 8'(rand_bits(8));
        set_status();
        set_trigger();
        exp_slot = (exp_slot + 1) % NUM_SLOT;
        load_rows(RXA_SLOT[exp_slot], 512);
        start_frame(BTYPE_DATA, 1'b0);
        wait_done();
        check_status(exp_slot);
        check_data_frame(exp_slot, 1'b1);
    endtask

    task automatic test_slot_rotation();
        for (int i = 0; i < NUM_DEV; i++)
            codes[i] = 2'd1;
        set_status();
        repeat (NUM_SLOT) begin
            exp_slot = (exp_slot + 1) % NUM_SLOT;   // 2, 3, 4, 5, 0, 1
            start_frame(BTYPE_DATA, 1'b0);
            wait_done();
            check_status(exp_slot);
            check_data_frame(exp_slot, 1'b0);
        end
    endtask

    task automatic test_errors();
        start_frame(4'd3, 1'b1);
        check_status(exp_slot);     // Busy stays low, nothing moves
        codes = '{2'd3, 2'd0, 2'd2, 2'd0, 2'd1, 2'd0, 2'd0, 2'd3};
        set_status();
        set_trigger();
        exp_slot = (exp_slot + 1) % NUM_SLOT;
        load_rows(RXA_SLOT[exp_slot], 512);
        start_frame(BTYPE_DATA, 1'b0);
        start_frame(BTYPE_INFO, 1'b1);
        wait_done();
        check_status(exp_slot);
        check_data_frame(exp_slot, 1'b1);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        smp_we   = 1'b0;
        smp_addr = '0;
        smp_data = '0;
        trig     = '0;
        exp_slot = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        test_registers();
        test_info_frame();
        test_data_frame();
        test_slot_rotation();
        test_errors();
        $display("Simulation passed");
        $finish;
    end

endmodule

/* flist.f */
hdl/frame_pkg.sv
hdl/sample_ram.sv
hdl/frame_ram.sv
hdl/frame_regs.sv
hdl/frame_builder.sv
hdl/frame_top.sv
sim/tb_frame_top.sv

/* Bender.yml */
package:
  name: frame_assembler

sources:
  - hdl/frame_pkg.sv
  - hdl/sample_ram.sv
  - hdl/frame_ram.sv
  - hdl/frame_regs.sv
  - hdl/frame_builder.sv
  - hdl/frame_top.sv
  - target: simulation
    files:
      - sim/tb_frame_top.sv
